//--- logic/frontend_pkg.sv
// fetch frontend shared types
`default_nettype none

package frontend_pkg;

  localparam int BLOCK_BYTES = 16;  // bytes per fetch block

  typedef logic [31:0] addr_t;
  typedef logic [5:0]  ghr_t;       // newest outcome in bit 0

  typedef enum logic [1:0] {
    br_cond,
    br_jump,
    br_call,
    br_ret
  } br_kind_e;

  // one fetch block moving down the pipe
  typedef struct packed {
    logic  valid;
    addr_t ip;
    ghr_t  ghr;   // history before this block
  } fetch_item_s;

  typedef struct packed {
    logic     hit;
    br_kind_e kind;
    addr_t    target;
  } btb_hit_s;

  // branch outcome from the back end
  typedef struct packed {
    addr_t    src;        // block address
    addr_t    target;
    br_kind_e kind;
    logic     taken;
    ghr_t     ghr;        // snapshot at prediction
    logic     mispredict;
  } resolve_s;

endpackage

`default_nettype wire

//--- logic/fetch_pc_gen.sv
// fetch address generator
`default_nettype none

module fetch_pc_gen #(
  parameter frontend_pkg::addr_t RESET_IP = 32'h1000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     redirect_valid,
  input  frontend_pkg::addr_t      redirect_ip,
  input  logic                     resolve_valid,
  input  frontend_pkg::resolve_s   resolve,
  input  frontend_pkg::ghr_t       cur_ghr,
  output frontend_pkg::fetch_item_s s1
);

  frontend_pkg::addr_t ip_q;
  frontend_pkg::addr_t fix_ip;
  logic                vld_q;   // low for a cycle after reset or squash
  logic                mispredict;

  assign mispredict = resolve_valid && resolve.mispredict;
  assign fix_ip = resolve.taken ? resolve.target
                                : resolve.src + frontend_pkg::addr_t'(frontend_pkg::BLOCK_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q  <= RESET_IP;
      vld_q <= 1'b0;
    end else if (mispredict) begin   // back end wins over the predictor
      ip_q  <= fix_ip;
      vld_q <= 1'b0;
    end else if (redirect_valid) begin
      ip_q  <= redirect_ip;
      vld_q <= 1'b1;
    end else if (vld_q) begin
      ip_q  <= ip_q + frontend_pkg::addr_t'(frontend_pkg::BLOCK_BYTES);
    end else begin
      vld_q <= 1'b1;                 // hold ip, issue it next cycle
    end
  end

  assign s1.valid = vld_q;
  assign s1.ip    = ip_q;
  assign s1.ghr   = cur_ghr;

endmodule

`default_nettype wire

//--- logic/branch_target_buffer.sv
// direct-mapped branch target buffer
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_IDX_W = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  frontend_pkg::addr_t    lookup_ip,
  output frontend_pkg::btb_hit_s hit,
  input  logic                   resolve_valid,
  input  frontend_pkg::resolve_s resolve
);

  localparam int OFF_W  = $clog2(frontend_pkg::BLOCK_BYTES);
  localparam int TAG_W  = $bits(frontend_pkg::addr_t) - OFF_W - BTB_IDX_W;
  localparam int N_SETS = 1 << BTB_IDX_W;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [TAG_W-1:0]     tag_t;

  logic [N_SETS-1:0]      valid_q;
  tag_t                   tag_mem  [N_SETS];
  frontend_pkg::br_kind_e kind_mem [N_SETS];
  frontend_pkg::addr_t    tgt_mem  [N_SETS];

  btb_idx_t rd_idx;
  btb_idx_t wr_idx;
  logic     wr_en;

  function automatic btb_idx_t idx_of(frontend_pkg::addr_t a);
    return a[OFF_W +: BTB_IDX_W];
  endfunction

  function automatic tag_t tag_of(frontend_pkg::addr_t a);
    return a[$bits(frontend_pkg::addr_t)-1 -: TAG_W];
  endfunction

  assign rd_idx = idx_of(lookup_ip);
  assign wr_idx = idx_of(resolve.src);
  assign wr_en  = resolve_valid && resolve.taken;  // not-taken cond keeps the entry

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx]  <= tag_of(resolve.src);
      kind_mem[wr_idx] <= resolve.kind;
      tgt_mem[wr_idx]  <= resolve.target;
    end
  end

  // registered lookup, old contents on a same-edge write
  always_ff @(posedge clk) begin
    hit.hit    <= valid_q[rd_idx] && (tag_mem[rd_idx] == tag_of(lookup_ip));
    hit.kind   <= kind_mem[rd_idx];
    hit.target <= tgt_mem[rd_idx];
    if (rst) hit.hit <= 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/direction_predictor.sv
// gshare direction predictor
`default_nettype none

module direction_predictor #(
  parameter int PHT_IDX_W = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  frontend_pkg::addr_t    lookup_ip,
  input  frontend_pkg::ghr_t     lookup_ghr,
  output logic                   predict_taken,
  input  logic                   resolve_valid,
  input  frontend_pkg::resolve_s resolve
);

  localparam int OFF_W    = $clog2(frontend_pkg::BLOCK_BYTES);
  localparam int PHT_SIZE = 1 << PHT_IDX_W;

  typedef logic [PHT_IDX_W-1:0] pht_idx_t;
  typedef logic [1:0]           ctr_t;

  ctr_t     pht [PHT_SIZE];
  pht_idx_t rd_idx;
  pht_idx_t upd_idx;
  ctr_t     upd_ctr;
  logic     upd_en;

  function automatic pht_idx_t pht_index(frontend_pkg::addr_t a, frontend_pkg::ghr_t h);
    return a[OFF_W +: PHT_IDX_W] ^ pht_idx_t'(h);
  endfunction

  assign rd_idx  = pht_index(lookup_ip, lookup_ghr);
  assign upd_idx = pht_index(resolve.src, resolve.ghr);  // snapshot, not live history
  assign upd_ctr = pht[upd_idx];
  assign upd_en  = resolve_valid && (resolve.kind == frontend_pkg::br_cond);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht[i] <= 2'b01;  // weakly not taken
      end
      predict_taken <= 1'b0;
    end else begin
      predict_taken <= pht[rd_idx][1];
      if (upd_en) begin
        if (resolve.taken && upd_ctr != 2'b11) begin
          pht[upd_idx] <= upd_ctr + 2'd1;
        end else if (!resolve.taken && upd_ctr != 2'b00) begin
          pht[upd_idx] <= upd_ctr - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/return_stack.sv
// return address stack
`default_nettype none

module return_stack #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  frontend_pkg::addr_t push_addr,
  input  logic                pop,
  output frontend_pkg::addr_t top
);

  localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  typedef logic [PTR_W-1:0] ras_ptr_t;
  typedef logic [CNT_W-1:0] ras_cnt_t;

  frontend_pkg::addr_t stack_mem [RAS_DEPTH];
  ras_ptr_t            sp_q;    // points at top entry
  ras_ptr_t            sp_inc;
  ras_ptr_t            sp_dec;
  ras_cnt_t            cnt_q;

  assign sp_inc = (sp_q == ras_ptr_t'(RAS_DEPTH - 1)) ? '0 : sp_q + 1'b1;
  assign sp_dec = (sp_q == '0) ? ras_ptr_t'(RAS_DEPTH - 1) : sp_q - 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      sp_q  <= '0;
      cnt_q <= '0;
    end else if (push) begin
      sp_q <= sp_inc;  // when full the oldest slot is reused
      if (cnt_q != ras_cnt_t'(RAS_DEPTH)) cnt_q <= cnt_q + 1'b1;
    end else if (pop && cnt_q != '0) begin
      sp_q  <= sp_dec;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) stack_mem[sp_inc] <= push_addr;
  end

  assign top = (cnt_q == '0) ? '0 : stack_mem[sp_q];

endmodule

`default_nettype wire

//--- logic/predict_stage.sv
// prediction stage and global history
`default_nettype none

module predict_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  frontend_pkg::fetch_item_s s1,
  input  frontend_pkg::btb_hit_s    hit,
  input  logic                      predict_taken,
  input  frontend_pkg::addr_t       ras_top,
  input  logic                      resolve_valid,
  input  frontend_pkg::resolve_s    resolve,
  output frontend_pkg::fetch_item_s s2,
  output logic                      pred_taken,
  output frontend_pkg::addr_t       pred_target,
  output logic                      redirect_valid,
  output frontend_pkg::addr_t       redirect_ip,
  output logic                      push,
  output logic                      pop,
  output frontend_pkg::addr_t       push_addr,
  output frontend_pkg::ghr_t        cur_ghr
);

  localparam int GHR_W = $bits(frontend_pkg::ghr_t);

  frontend_pkg::fetch_item_s item_q;
  frontend_pkg::ghr_t        ghr_q;
  frontend_pkg::ghr_t        ghr_next;
  logic                      mispredict;
  logic                      br_hit;
  logic                      cond_hit;

  assign mispredict = resolve_valid && resolve.mispredict;

  always_ff @(posedge clk) begin
    item_q <= s1;
    // younger block behind a taken prediction is dropped
    if (rst || redirect_valid || mispredict) item_q.valid <= 1'b0;
  end

  assign br_hit   = item_q.valid && hit.hit;
  assign cond_hit = br_hit && (hit.kind == frontend_pkg::br_cond);

  // unconditional kinds always taken
  assign pred_taken  = br_hit && (hit.kind != frontend_pkg::br_cond || predict_taken);
  assign pred_target = (hit.kind == frontend_pkg::br_ret) ? ras_top : hit.target;

  assign redirect_valid = pred_taken;
  assign redirect_ip    = pred_target;

  assign push      = pred_taken && (hit.kind == frontend_pkg::br_call);
  assign pop       = pred_taken && (hit.kind == frontend_pkg::br_ret);
  assign push_addr = item_q.ip + frontend_pkg::addr_t'(frontend_pkg::BLOCK_BYTES);

  always_comb begin
    if (mispredict) begin
      ghr_next = {resolve.ghr[GHR_W-2:0], resolve.taken};  // rebuild from snapshot
    end else if (cond_hit) begin
      ghr_next = {ghr_q[GHR_W-2:0], predict_taken};
    end else begin
      ghr_next = ghr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ghr_q <= '0;
    end else begin
      ghr_q <= ghr_next;
    end
  end

  // next block sees this block's outcome
  assign cur_ghr = ghr_next;
  assign s2      = item_q;

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
// instruction fetch frontend
`default_nettype none

module frontend_top #(
  parameter frontend_pkg::addr_t RESET_IP = 32'h1000,
  parameter int BTB_IDX_W = 4,
  parameter int PHT_IDX_W = 6,
  parameter int RAS_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   resolve_valid,
  input  frontend_pkg::resolve_s resolve,
  output logic                   fetch_valid,
  output frontend_pkg::addr_t    fetch_ip,
  output logic                   pred_taken,
  output frontend_pkg::addr_t    pred_target
);

  frontend_pkg::fetch_item_s s1;
  frontend_pkg::fetch_item_s s2;
  frontend_pkg::btb_hit_s    hit;
  frontend_pkg::addr_t       ras_top;
  frontend_pkg::addr_t       redirect_ip;
  frontend_pkg::addr_t       push_addr;
  frontend_pkg::ghr_t        cur_ghr;
  logic                      predict_taken;
  logic                      redirect_valid;
  logic                      push;
  logic                      pop;

  fetch_pc_gen #(.RESET_IP(RESET_IP)) pc_gen0 (
    .clk, .rst, .redirect_valid, .redirect_ip, .resolve_valid, .resolve, .cur_ghr, .s1
  );

  branch_target_buffer #(.BTB_IDX_W(BTB_IDX_W)) btb0 (
    .clk, .rst, .lookup_ip(s1.ip), .hit, .resolve_valid, .resolve
  );

  direction_predictor #(.PHT_IDX_W(PHT_IDX_W)) dir0 (
    .clk, .rst, .lookup_ip(s1.ip), .lookup_ghr(s1.ghr), .predict_taken,
    .resolve_valid, .resolve
  );

  return_stack #(.RAS_DEPTH(RAS_DEPTH)) ras0 (
    .clk, .rst, .push, .push_addr, .pop, .top(ras_top)
  );

  predict_stage pred0 (
    .clk, .rst, .s1, .hit, .predict_taken, .ras_top, .resolve_valid, .resolve,
    .s2, .pred_taken, .pred_target, .redirect_valid, .redirect_ip,
    .push, .pop, .push_addr, .cur_ghr
  );

  assign fetch_valid = s2.valid;
  assign fetch_ip    = s2.ip;

endmodule

`default_nettype wire

//--- tests/tb_frontend.sv
// fetch frontend testbench
`default_nettype none

module tb_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam frontend_pkg::addr_t RESET_IP = 32'h1000;
  localparam frontend_pkg::addr_t JMP_SRC  = 32'h1030;
  localparam frontend_pkg::addr_t CALL_SRC = 32'h1050;
  localparam frontend_pkg::addr_t COND_SRC = 32'h1070;
  localparam frontend_pkg::addr_t RET_ALT  = 32'h10a0;  // return seen from another caller
  localparam frontend_pkg::addr_t HOP_SRC  = 32'h10f0;  // steers fetch and is never fetched itself
  localparam frontend_pkg::addr_t FUNC_IP  = 32'h2000;
  localparam int MAX_WAIT = 16;

  // table row with an optional resolve and the next valid block
  typedef struct packed {
    logic                   res_valid;
    frontend_pkg::resolve_s res;
    frontend_pkg::addr_t    ip;
    logic [3:0]             gap;     // invalid cycles before the block
    logic                   taken;
    frontend_pkg::addr_t    target;
  } step_s;

  logic                   clk;
  logic                   rst;
  logic                   resolve_valid;
  frontend_pkg::resolve_s resolve;
  logic                   fetch_valid;
  frontend_pkg::addr_t    fetch_ip;
  logic                   pred_taken;
  frontend_pkg::addr_t    pred_target;

  step_s                  steps [$];
  string                  names [$];
  frontend_pkg::ghr_t     hist;   // history as the frontend should hold it
  frontend_pkg::ghr_t     snap;
  frontend_pkg::resolve_s r;
  frontend_pkg::addr_t    jmp_tgt;
  frontend_pkg::addr_t    cond_tgt;

  frontend_top #(.RESET_IP(RESET_IP), .BTB_IDX_W(4), .PHT_IDX_W(6), .RAS_DEPTH(4)) dut0 (
    .clk, .rst, .resolve_valid, .resolve, .fetch_valid, .fetch_ip, .pred_taken, .pred_target
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_addr(input string name, input frontend_pkg::addr_t exp,
                              input frontend_pkg::addr_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic verify_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b, got %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic match_gap(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error %s: expected %0d, got %0d", name, exp, act);
      abort_run();
    end
  endtask

  function automatic frontend_pkg::resolve_s make_resolve(
    frontend_pkg::addr_t src, frontend_pkg::addr_t target, frontend_pkg::br_kind_e kind,
    logic taken, frontend_pkg::ghr_t ghr, logic mispredict);
    frontend_pkg::resolve_s res;
    res.src        = src;
    res.target     = target;
    res.kind       = kind;
    res.taken      = taken;
    res.ghr        = ghr;
    res.mispredict = mispredict;
    return res;
  endfunction

  // newest outcome enters at bit 0
  function automatic frontend_pkg::ghr_t shift_history(frontend_pkg::ghr_t h, logic taken);
    return {h[$bits(frontend_pkg::ghr_t)-2:0], taken};
  endfunction

  // block aligned address inside a 4 KB window
  function automatic frontend_pkg::addr_t pick_target(frontend_pkg::addr_t base);
    return base + frontend_pkg::addr_t'(($urandom % 256) << 4);
  endfunction

  task automatic add_step(input string name, input logic rv, input frontend_pkg::resolve_s res,
                          input frontend_pkg::addr_t ip, input int gap, input logic taken,
                          input frontend_pkg::addr_t target);
    steps.push_back('{rv, res, ip, 4'(gap), taken, target});
    names.push_back(name);
  endtask

  task automatic build_table();
    add_step("reset_ip0", 1'b0, '0, RESET_IP, 1, 1'b0, '0);
    add_step("reset_ip1", 1'b0, '0, RESET_IP + 16, 0, 1'b0, '0);
    add_step("reset_ip2", 1'b0, '0, RESET_IP + 32, 0, 1'b0, '0);
    // jump learned through a mispredict and then predicted
    r = make_resolve(JMP_SRC, jmp_tgt, frontend_pkg::br_jump, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("jump_fix", 1'b1, r, jmp_tgt, 2, 1'b0, '0);
    add_step("jump_fix_next", 1'b0, '0, jmp_tgt + 16, 0, 1'b0, '0);
    r = make_resolve(HOP_SRC, JMP_SRC, frontend_pkg::br_jump, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("jump_refetch", 1'b1, r, JMP_SRC, 2, 1'b1, jmp_tgt);
    add_step("jump_predicted", 1'b0, '0, jmp_tgt, 1, 1'b0, '0);
    // call and return
    r = make_resolve(CALL_SRC, FUNC_IP, frontend_pkg::br_call, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("call_fix", 1'b1, r, FUNC_IP, 2, 1'b0, '0);
    r = make_resolve(FUNC_IP, RET_ALT, frontend_pkg::br_ret, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("ret_fix", 1'b1, r, RET_ALT, 2, 1'b0, '0);
    r = make_resolve(HOP_SRC, CALL_SRC, frontend_pkg::br_jump, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("call_refetch", 1'b1, r, CALL_SRC, 2, 1'b1, FUNC_IP);
    add_step("ret_predicted", 1'b0, '0, FUNC_IP, 1, 1'b1, CALL_SRC + 16);
    add_step("ret_target", 1'b0, '0, CALL_SRC + 16, 1, 1'b0, '0);
    // cond trained with the history the next refetch will give
    snap = shift_history(hist, 1'b1);
    r = make_resolve(COND_SRC, cond_tgt, frontend_pkg::br_cond, 1'b1, snap, 1'b0);
    add_step("cond_up0", 1'b1, r, COND_SRC, 0, 1'b0, '0);
    add_step("cond_up1", 1'b1, r, COND_SRC + 16, 0, 1'b0, '0);
    r = make_resolve(HOP_SRC, COND_SRC, frontend_pkg::br_jump, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("cond_taken", 1'b1, r, COND_SRC, 2, 1'b1, cond_tgt);
    hist = shift_history(hist, 1'b1);  // predicted taken cond
    add_step("cond_taken_next", 1'b0, '0, cond_tgt, 1, 1'b0, '0);
    snap = shift_history(hist, 1'b1);
    r = make_resolve(COND_SRC, cond_tgt, frontend_pkg::br_cond, 1'b0, snap, 1'b0);
    add_step("cond_down0", 1'b1, r, cond_tgt + 16, 0, 1'b0, '0);
    add_step("cond_down1", 1'b1, r, cond_tgt + 32, 0, 1'b0, '0);
    r = make_resolve(HOP_SRC, COND_SRC, frontend_pkg::br_jump, 1'b1, hist, 1'b1);
    hist = shift_history(hist, 1'b1);
    add_step("cond_not_taken", 1'b1, r, COND_SRC, 2, 1'b0, '0);
    hist = shift_history(hist, 1'b0);
    add_step("cond_fall_through", 1'b0, '0, COND_SRC + 16, 0, 1'b0, '0);
    // squash of the blocks in flight
    r = make_resolve(COND_SRC + 16, cond_tgt, frontend_pkg::br_cond, 1'b0, hist, 1'b1);
    hist = shift_history(hist, 1'b0);
    add_step("squash_fix", 1'b1, r, COND_SRC + 32, 2, 1'b0, '0);
    add_step("squash_next", 1'b0, '0, COND_SRC + 48, 0, 1'b0, '0);
  endtask

  task automatic wait_fetch_valid(input string name, output int gap);
    bit seen;
    seen = 1'b0;
    gap  = 0;
    while (!seen) begin
      @(posedge clk);
      #1;
      resolve_valid = 1'b0;  // strobe lasts one edge
      if (fetch_valid === 1'b1) begin
        seen = 1'b1;
      end else if (gap == MAX_WAIT) begin
        $display("timeout at %s: no valid fetch block within %0d cycles", name, MAX_WAIT);
        abort_run();
      end else begin
        gap++;
      end
    end
  endtask

  task automatic run_step(input int i);
    int gap;
    if (steps[i].res_valid) begin
      resolve_valid = 1'b1;
      resolve       = steps[i].res;
    end
    wait_fetch_valid(names[i], gap);
    match_gap({names[i], " bubbles"}, int'(steps[i].gap), gap);
    compare_addr({names[i], " fetch_ip"}, steps[i].ip, fetch_ip);
    verify_bit({names[i], " pred_taken"}, steps[i].taken, pred_taken);
    if (steps[i].taken) begin
      compare_addr({names[i], " pred_target"}, steps[i].target, pred_target);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    resolve_valid = 1'b0;
    resolve       = '0;
    void'($urandom(32'h65b6));
    jmp_tgt       = pick_target(32'h4000);
    cond_tgt      = pick_target(32'h3000);
    hist          = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/frontend_pkg.sv
logic/fetch_pc_gen.sv
logic/branch_target_buffer.sv
logic/direction_predictor.sv
logic/return_stack.sv
logic/predict_stage.sv
logic/frontend_top.sv
tests/tb_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - logic/frontend_pkg.sv
      - logic/fetch_pc_gen.sv
      - logic/branch_target_buffer.sv
      - logic/direction_predictor.sv
      - logic/return_stack.sv
      - logic/predict_stage.sv
      - logic/frontend_top.sv
  - target: test
    files:
      - tests/tb_frontend.sv
